// File: include/mdll_jm_regmap.svh
`ifndef MDLL_JM_REGMAP_SVH
`define MDLL_JM_REGMAP_SVH
`default_nettype none

// wishbone word addresses
`define JM_ADR_CTRL      0
`define JM_ADR_STAT      1
// cdf window, one word per phase code
`define JM_ADR_CDF_BASE  32

// control register bits
`define JM_CTRL_START    0
`define JM_CTRL_POL      1

// status register bits, read only
`define JM_STAT_BUSY     0
`define JM_STAT_DONE     1
`define JM_STAT_CODE_LSB 8
`define JM_STAT_CODE_MSB 12

`default_nettype wire
`endif

// File: mdll_jm.f
+incdir+include
verilog/mdll_pkg.sv
verilog/mdll_jmeas.sv
verilog/mdll_jm_sweep.sv
verilog/mdll_jm_cdf_ram.sv
verilog/mdll_jm_wb_regs.sv
verilog/mdll_jm_top.sv
tb/mdll_jm_checker.sv
tb/tb_mdll_jm.sv

// File: run_sim.sh
#!/bin/sh
# build and run the jitter monitor testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_mdll_jm \
	-Mdir obj_dir -f mdll_jm.f; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_mdll_jm)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb/mdll_jm_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mdll_jm_checker (
	input wire                            clk_monp,
	input wire                            en_monitor,
	input wire                            wb_cyc,
	input wire                            wb_stb,
	input wire                            wb_ack,
	input wire                            sweep_busy,
	input wire [mdll_pkg::N_PI_CODE-1:0] jm_pi_code
);

	// --------------------------------------------------
	// wishbone handshake
	// --------------------------------------------------
	// classic ack, one cycle only
	ack_single: assert property (@(posedge clk_monp) disable iff (!en_monitor)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for two consecutive cycles");

	// ack answers a request of the previous cycle
	ack_after_req: assert property (@(posedge clk_monp) disable iff (!en_monitor)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without cyc and stb in the previous cycle");

	// --------------------------------------------------
	// sweep
	// --------------------------------------------------
	// code moves while busy, the step back to 0 included
	code_in_sweep: assert property (@(posedge clk_monp) disable iff (!en_monitor)
		(jm_pi_code != $past(jm_pi_code)) |-> $past(sweep_busy))
		else $error("jm_pi_code changed while the sweep was idle");

endmodule

bind mdll_jm_top mdll_jm_checker u_checker (
	.clk_monp   (clk_monp),
	.en_monitor (en_monitor),
	.wb_cyc     (wb_cyc),
	.wb_stb     (wb_stb),
	.wb_ack     (wb_ack),
	.sweep_busy (sweep_busy),
	.jm_pi_code (jm_pi_code)
);

`default_nettype wire

// File: tb/mdll_jm_input.txt
// per phase code: detector level, expected cdf word at polarity 1
// a word after a level change keeps two counts from the previous code
0 000
0 000
0 000
0 000
0 000
0 000
0 000
0 000
0 000
0 000
0 000
0 000
1 3FD
0 002
1 3FD
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF
1 3FF

// File: tb/tb_mdll_jm.sv
`include "mdll_jm_regmap.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_mdll_jm;
	import mdll_pkg::*;

	// wait limits in cycles or polls
	localparam int ACK_LIMIT  = 16;
	localparam int POLL_GAP   = 256;
	localparam int POLL_LIMIT = 200;
	// discard window plus 32 windows plus poll lag
	localparam int SWEEP_MAX  = 34 << N_JIT_CNT;

	logic                 clk_monp;
	logic                 en_monitor;
	logic                 jm_bb_out_mon = 1'b0;
	wire  [N_PI_CODE-1:0] jm_pi_code;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [N_WB_ADR-1:0]  wb_adr;
	logic [N_WB_DAT-1:0]  wb_dat_w;
	wire  [N_WB_DAT-1:0]  wb_dat_r;
	wire                  wb_ack;

	// even entry level, odd entry expected word
	logic [N_JIT_CNT-1:0] stim_mem [2*N_PI_STEPS];
	integer               seed;
	int                   cycle_cnt = 0;
	int                   t_start;
	logic [N_WB_DAT-1:0]  rdata;
	logic                 saw_busy;

	mdll_jm_top uut (
		.clk_monp      (clk_monp),
		.en_monitor    (en_monitor),
		.jm_bb_out_mon (jm_bb_out_mon),
		.jm_pi_code    (jm_pi_code),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack)
	);

	initial clk_monp = 1'b0;
	always #4 clk_monp = ~clk_monp;

	always @(posedge clk_monp) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// bang-bang detector model with the level of the current phase code
	always @(posedge clk_monp) begin
		jm_bb_out_mon <= stim_mem[{jm_pi_code, 1'b0}][0];
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [N_WB_DAT-1:0] got,
		input logic [N_WB_DAT-1:0] want);
		assert (got === want) else begin
			stop_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, want));
		end
	endtask

	function automatic logic [N_WB_DAT-1:0] ctrl_value(input logic pol, input logic start);
		logic [N_WB_DAT-1:0] w;
		w = '0;
		w[`JM_CTRL_POL]   = pol;
		w[`JM_CTRL_START] = start;
		return w;
	endfunction

	// pol 0 inverts each hit so the word is the 10 bit complement
	function automatic logic [N_JIT_CNT-1:0] expected_word(input int code, input logic pol);
		logic [N_PI_CODE:0] idx;
		idx = {code[N_PI_CODE-1:0], 1'b1};
		return pol ? stim_mem[idx] : ~stim_mem[idx];
	endfunction

	task automatic apply_reset();
		@(posedge clk_monp);
		en_monitor <= 1'b0;
		repeat (3) @(posedge clk_monp);
		en_monitor <= 1'b1;
	endtask

	// one classic cycle followed by a random idle gap
	task automatic bus_cycle(input logic we, input int adr, input logic [N_WB_DAT-1:0] wdat,
		output logic [N_WB_DAT-1:0] rdat);
		int          waited;
		int unsigned gap;
		waited = 0;
		@(posedge clk_monp);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= N_WB_ADR'(adr);
		wb_dat_w <= wdat;
		// ack and data looked at mid cycle
		do begin
			@(negedge clk_monp);
			waited++;
			if (waited > ACK_LIMIT) begin
				stop_run("no wb_ack from the slave within the timeout");
			end
		end while (!wb_ack);
		rdat = wb_dat_r;
		@(posedge clk_monp);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(posedge clk_monp);
	endtask

	task automatic write_reg(input int adr, input logic [N_WB_DAT-1:0] wdat);
		logic [N_WB_DAT-1:0] ignored;
		bus_cycle(1'b1, adr, wdat, ignored);
	endtask

	task automatic read_reg(input int adr, output logic [N_WB_DAT-1:0] rdat);
		bus_cycle(1'b0, adr, '0, rdat);
	endtask

	// status polls until done and notes busy on the way
	task automatic poll_done(output logic seen_busy);
		logic [N_WB_DAT-1:0] stat;
		int                  polls;
		polls     = 0;
		seen_busy = 1'b0;
		do begin
			read_reg(`JM_ADR_STAT, stat);
			seen_busy = seen_busy | stat[`JM_STAT_BUSY];
			polls++;
			if (polls > POLL_LIMIT) begin
				stop_run("sweep did not report done within the timeout");
			end
			if (!stat[`JM_STAT_DONE]) begin
				repeat (POLL_GAP) @(posedge clk_monp);
			end
		end while (!stat[`JM_STAT_DONE]);
	endtask

	// status polls until the sweep reaches a code
	task automatic await_code(input int min_code);
		logic [N_WB_DAT-1:0] stat;
		int                  polls;
		polls = 0;
		do begin
			read_reg(`JM_ADR_STAT, stat);
			polls++;
			if (polls > POLL_LIMIT) begin
				stop_run("sweep did not reach the phase code within the timeout");
			end
			if (stat[`JM_STAT_CODE_MSB:`JM_STAT_CODE_LSB] < N_PI_CODE'(min_code)) begin
				repeat (POLL_GAP) @(posedge clk_monp);
			end
		end while (stat[`JM_STAT_CODE_MSB:`JM_STAT_CODE_LSB] < N_PI_CODE'(min_code));
	endtask

	task automatic verify_cdf(input logic pol);
		logic [N_WB_DAT-1:0] word;
		for (int code = 0; code < N_PI_STEPS; code++) begin
			read_reg(`JM_ADR_CDF_BASE + code, word);
			check_value($sformatf("wb_dat_r cdf code %0d", code), word,
				N_WB_DAT'(expected_word(code, pol)));
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		seed       = 15513;
		en_monitor = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		$readmemh("tb/mdll_jm_input.txt", stim_mem);
		apply_reset();

		// idle after reset
		read_reg(`JM_ADR_STAT, rdata);
		check_value("wb_dat_r status after reset", rdata, '0);
		read_reg(`JM_ADR_CTRL, rdata);
		check_value("wb_dat_r ctrl after reset", rdata, '0);

		// sweep at polarity 1
		write_reg(`JM_ADR_CTRL, ctrl_value(1'b1, 1'b1));
		read_reg(`JM_ADR_CTRL, rdata);
		check_value("wb_dat_r ctrl polarity", rdata, ctrl_value(1'b1, 1'b0));
		poll_done(saw_busy);
		check_value("busy seen during sweep", N_WB_DAT'(saw_busy), 1);
		read_reg(`JM_ADR_STAT, rdata);
		check_value("wb_dat_r status after sweep", rdata, N_WB_DAT'(1) << `JM_STAT_DONE);
		// code port back at 0 once the sweep is over
		@(negedge clk_monp);
		check_value("jm_pi_code after sweep", N_WB_DAT'(jm_pi_code), '0);
		verify_cdf(1'b1);

		// sweep at polarity 0 gives complemented words
		write_reg(`JM_ADR_CTRL, ctrl_value(1'b0, 1'b1));
		poll_done(saw_busy);
		read_reg(`JM_ADR_STAT, rdata);
		check_value("wb_dat_r status after sweep", rdata, N_WB_DAT'(1) << `JM_STAT_DONE);
		verify_cdf(1'b0);

		// second start while busy is dropped
		t_start = cycle_cnt;
		write_reg(`JM_ADR_CTRL, ctrl_value(1'b1, 1'b1));
		read_reg(`JM_ADR_STAT, rdata);
		check_value("wb_dat_r status at sweep start", rdata, N_WB_DAT'(1) << `JM_STAT_BUSY);
		// a restart from here would overrun one full sweep
		await_code(4);
		write_reg(`JM_ADR_CTRL, ctrl_value(1'b1, 1'b1));
		poll_done(saw_busy);
		assert (cycle_cnt - t_start <= SWEEP_MAX) else begin
			stop_run("sweep took longer than one full sweep after a start during busy");
		end
		repeat (2 << N_JIT_CNT) @(posedge clk_monp);
		read_reg(`JM_ADR_STAT, rdata);
		check_value("wb_dat_r status two windows after done", rdata,
			N_WB_DAT'(1) << `JM_STAT_DONE);
		verify_cdf(1'b1);

		// reset in the middle of a sweep
		write_reg(`JM_ADR_CTRL, ctrl_value(1'b1, 1'b1));
		await_code(4);
		apply_reset();
		read_reg(`JM_ADR_STAT, rdata);
		check_value("wb_dat_r status after mid sweep reset", rdata, '0);
		read_reg(`JM_ADR_CTRL, rdata);
		check_value("wb_dat_r ctrl after mid sweep reset", rdata, '0);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/mdll_jm_cdf_ram.sv
`timescale 1ns/1ns
`default_nettype none

module mdll_jm_cdf_ram (
	input  wire                              clk_monp,
	input  wire                              cdf_we,
	input  wire  [mdll_pkg::N_PI_CODE-1:0] cdf_waddr,
	input  wire  [mdll_pkg::N_JIT_CNT-1:0] cdf_wdata,
	input  wire  [mdll_pkg::N_PI_CODE-1:0] cdf_raddr,
	output logic [mdll_pkg::N_JIT_CNT-1:0] cdf_rdata
);
	import mdll_pkg::*;

	// one cdf sample per phase code
	logic [N_JIT_CNT-1:0] mem [N_PI_STEPS];

	// write port
	always_ff @(posedge clk_monp) begin
		if (cdf_we) begin
			mem[cdf_waddr] <= cdf_wdata;
		end
	end

	// registered read, one cycle latency
	// same address write shows next cycle
	always_ff @(posedge clk_monp) begin
		cdf_rdata <= mem[cdf_raddr];
	end

endmodule

`default_nettype wire

// File: verilog/mdll_jm_sweep.sv
`timescale 1ns/1ns
`default_nettype none

module mdll_jm_sweep (
	input  wire                              clk_monp,
	input  wire                              en_monitor,
	input  wire                              sweep_start,
	input  wire                              jm_cdf_valid,
	input  wire  [mdll_pkg::N_JIT_CNT-1:0] jm_cdf_out,
	output logic [mdll_pkg::N_PI_CODE-1:0] jm_pi_code,
	output logic                             sweep_busy,
	output logic                             sweep_done,
	output logic                             cdf_we,
	output logic [mdll_pkg::N_PI_CODE-1:0] cdf_waddr,
	output logic [mdll_pkg::N_JIT_CNT-1:0] cdf_wdata
);
	import mdll_pkg::*;

	// idle, partial first window, collecting
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DISCARD,
		ST_COLLECT
	} sweep_state_t;

	sweep_state_t state;
	// highest phase code reached
	logic         last_code;

	assign last_code  = (jm_pi_code == N_PI_CODE'(N_PI_STEPS - 1));
	assign sweep_busy = (state != ST_IDLE);

	// --------------------------------------------------
	// cdf write port
	// --------------------------------------------------
	// sample goes to the code it was taken at
	assign cdf_we    = (state == ST_COLLECT) && jm_cdf_valid;
	assign cdf_waddr = jm_pi_code;
	assign cdf_wdata = jm_cdf_out;

	// --------------------------------------------------
	// sequencer
	// --------------------------------------------------
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			state      <= ST_IDLE;
			jm_pi_code <= '0;
			sweep_done <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// start only taken while idle
					if (sweep_start) begin
						state      <= ST_DISCARD;
						jm_pi_code <= '0;
						sweep_done <= 1'b0;
					end
				end
				ST_DISCARD: begin
					// window was already running at start
					if (jm_cdf_valid) begin
						state <= ST_COLLECT;
					end
				end
				ST_COLLECT: begin
					if (jm_cdf_valid) begin
						if (last_code) begin
							// all codes written
							state      <= ST_IDLE;
							jm_pi_code <= '0;
							sweep_done <= 1'b1;
						end else begin
							jm_pi_code <= jm_pi_code + N_PI_CODE'(1);
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/mdll_jm_top.sv
`timescale 1ns/1ns
`default_nettype none

module mdll_jm_top (
	input  wire                              clk_monp,
	input  wire                              en_monitor,
	input  wire                              jm_bb_out_mon,
	output wire  [mdll_pkg::N_PI_CODE-1:0] jm_pi_code,
	input  wire                              wb_cyc,
	input  wire                              wb_stb,
	input  wire                              wb_we,
	input  wire  [mdll_pkg::N_WB_ADR-1:0]  wb_adr,
	input  wire  [mdll_pkg::N_WB_DAT-1:0]  wb_dat_w,
	output wire  [mdll_pkg::N_WB_DAT-1:0]  wb_dat_r,
	output wire                              wb_ack
);
	import mdll_pkg::*;

	// measurement to sweep
	wire [N_JIT_CNT-1:0] jm_cdf_out;
	wire                 jm_cdf_valid;
	// register controls
	wire                 jm_bb_out_pol;
	wire                 sweep_start;
	wire                 sweep_busy;
	wire                 sweep_done;
	// cdf memory ports
	wire                 cdf_we;
	wire [N_PI_CODE-1:0] cdf_waddr;
	wire [N_JIT_CNT-1:0] cdf_wdata;
	wire [N_PI_CODE-1:0] cdf_raddr;
	wire [N_JIT_CNT-1:0] cdf_rdata;

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	// hit counting per window
	mdll_jmeas u_jmeas (
		.clk_monp      (clk_monp),
		.en_monitor    (en_monitor),
		.jm_bb_out_pol (jm_bb_out_pol),
		.jm_bb_out_mon (jm_bb_out_mon),
		.jm_cdf_out    (jm_cdf_out),
		.jm_cdf_valid  (jm_cdf_valid)
	);

	// phase code stepping
	mdll_jm_sweep u_sweep (
		.clk_monp     (clk_monp),
		.en_monitor   (en_monitor),
		.sweep_start  (sweep_start),
		.jm_cdf_valid (jm_cdf_valid),
		.jm_cdf_out   (jm_cdf_out),
		.jm_pi_code   (jm_pi_code),
		.sweep_busy   (sweep_busy),
		.sweep_done   (sweep_done),
		.cdf_we       (cdf_we),
		.cdf_waddr    (cdf_waddr),
		.cdf_wdata    (cdf_wdata)
	);

	mdll_jm_cdf_ram u_cdf_ram (
		.clk_monp  (clk_monp),
		.cdf_we    (cdf_we),
		.cdf_waddr (cdf_waddr),
		.cdf_wdata (cdf_wdata),
		.cdf_raddr (cdf_raddr),
		.cdf_rdata (cdf_rdata)
	);

	// --------------------------------------------------
	// host access
	// --------------------------------------------------
	mdll_jm_wb_regs u_wb_regs (
		.clk_monp      (clk_monp),
		.en_monitor    (en_monitor),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.jm_bb_out_pol (jm_bb_out_pol),
		.sweep_start   (sweep_start),
		.sweep_busy    (sweep_busy),
		.sweep_done    (sweep_done),
		.jm_pi_code    (jm_pi_code),
		.cdf_raddr     (cdf_raddr),
		.cdf_rdata     (cdf_rdata)
	);

endmodule

`default_nettype wire

// File: verilog/mdll_jm_wb_regs.sv
`include "mdll_jm_regmap.svh"
`timescale 1ns/1ns
`default_nettype none

module mdll_jm_wb_regs (
	input  wire                              clk_monp,
	input  wire                              en_monitor,
	input  wire                              wb_cyc,
	input  wire                              wb_stb,
	input  wire                              wb_we,
	input  wire  [mdll_pkg::N_WB_ADR-1:0]  wb_adr,
	input  wire  [mdll_pkg::N_WB_DAT-1:0]  wb_dat_w,
	output logic [mdll_pkg::N_WB_DAT-1:0]  wb_dat_r,
	output logic                             wb_ack,
	output logic                             jm_bb_out_pol,
	output logic                             sweep_start,
	input  wire                              sweep_busy,
	input  wire                              sweep_done,
	input  wire  [mdll_pkg::N_PI_CODE-1:0] jm_pi_code,
	output logic [mdll_pkg::N_PI_CODE-1:0] cdf_raddr,
	input  wire  [mdll_pkg::N_JIT_CNT-1:0] cdf_rdata
);
	import mdll_pkg::*;

	// new request, not yet acked
	logic                req;
	logic                sel_cdf;
	logic                sel_ctrl;
	logic                sel_stat;
	logic                wr_ctrl;
	// read source captured at the request
	logic                rd_sel_cdf;
	logic [N_WB_DAT-1:0] rd_word;
	logic [N_WB_DAT-1:0] ctrl_word;
	logic [N_WB_DAT-1:0] stat_word;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	assign req      = wb_cyc && wb_stb && !wb_ack;
	assign sel_cdf  = (wb_adr >= N_WB_ADR'(`JM_ADR_CDF_BASE));
	assign sel_ctrl = (wb_adr == N_WB_ADR'(`JM_ADR_CTRL));
	assign sel_stat = (wb_adr == N_WB_ADR'(`JM_ADR_STAT));
	assign wr_ctrl  = req && wb_we && sel_ctrl;

	// low address bits pick the code
	// ram data lands together with the ack
	assign cdf_raddr = wb_adr[N_PI_CODE-1:0];

	// --------------------------------------------------
	// register views
	// --------------------------------------------------
	// start bit reads back as zero
	always_comb begin
		ctrl_word = '0;
		ctrl_word[`JM_CTRL_POL] = jm_bb_out_pol;
	end

	always_comb begin
		stat_word = '0;
		stat_word[`JM_STAT_BUSY] = sweep_busy;
		stat_word[`JM_STAT_DONE] = sweep_done;
		stat_word[`JM_STAT_CODE_MSB:`JM_STAT_CODE_LSB] = jm_pi_code;
	end

	// --------------------------------------------------
	// control and handshake
	// --------------------------------------------------
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			wb_ack        <= 1'b0;
			jm_bb_out_pol <= 1'b0;
			sweep_start   <= 1'b0;
		end else begin
			// classic cycle, one ack per request
			wb_ack      <= req;
			// single cycle pulse per ctrl write
			sweep_start <= wr_ctrl && wb_dat_w[`JM_CTRL_START];
			if (wr_ctrl) begin
				jm_bb_out_pol <= wb_dat_w[`JM_CTRL_POL];
			end
		end
	end

	// read data for ctrl and stat
	always_ff @(posedge clk_monp) begin
		if (req) begin
			rd_sel_cdf <= sel_cdf;
			if (sel_stat) begin
				rd_word <= stat_word;
			end else if (sel_ctrl) begin
				rd_word <= ctrl_word;
			end else begin
				rd_word <= '0;
			end
		end
	end

	// cdf words zero extended
	assign wb_dat_r = rd_sel_cdf ? N_WB_DAT'(cdf_rdata) : rd_word;

endmodule

`default_nettype wire

// File: verilog/mdll_jmeas.sv
`timescale 1ns/1ns
`default_nettype none

module mdll_jmeas (
	input  wire                              clk_monp,
	input  wire                              en_monitor,
	input  wire                              jm_bb_out_pol,
	input  wire                              jm_bb_out_mon,
	output logic [mdll_pkg::N_JIT_CNT-1:0] jm_cdf_out,
	output logic                             jm_cdf_valid
);
	import mdll_pkg::*;

	// polarity corrected detector bit
	logic                 hit;
	// last cycle of the window
	logic                 sample;
	logic [N_JIT_CNT-1:0] pulse_cntr;
	logic [N_JIT_CNT-1:0] hit_cntr;

	// pol 1 keeps the bit, pol 0 inverts it
	assign hit    = jm_bb_out_pol ? jm_bb_out_mon : ~jm_bb_out_mon;
	assign sample = &pulse_cntr;

	// --------------------------------------------------
	// window timing
	// --------------------------------------------------
	// free running, wraps every 2^N_JIT_CNT clocks
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			pulse_cntr <= '0;
		end else begin
			pulse_cntr <= pulse_cntr + N_JIT_CNT'(1);
		end
	end

	// --------------------------------------------------
	// hit counting
	// --------------------------------------------------
	// restarts at the window edge, holds at all ones
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			hit_cntr <= '0;
		end else if (sample) begin
			hit_cntr <= '0;
		end else if (hit && !(&hit_cntr)) begin
			hit_cntr <= hit_cntr + N_JIT_CNT'(1);
		end
	end

	// sample out plus one cycle strobe
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			jm_cdf_out   <= '0;
			jm_cdf_valid <= 1'b0;
		end else begin
			jm_cdf_valid <= sample;
			// count of the window just closed
			if (sample) begin
				jm_cdf_out <= hit_cntr;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mdll_pkg.sv
`default_nettype none

package mdll_pkg;

	// --------------------------------------------------
	// jitter counter
	// --------------------------------------------------
	// window length is 2^N_JIT_CNT monitor clocks
	localparam int N_JIT_CNT = 10;

	// --------------------------------------------------
	// phase interpolator
	// --------------------------------------------------
	localparam int N_PI_CODE = 5;
	// one cdf sample per code
	localparam int N_PI_STEPS = 1 << N_PI_CODE;

	// --------------------------------------------------
	// wishbone
	// --------------------------------------------------
	localparam int N_WB_DAT = 32;
	// word address, covers regs and the cdf window
	localparam int N_WB_ADR = 6;

endpackage

`default_nettype wire
